// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_act_weight_sync -Mdir obj_dir
	./obj_dir/Vtb_act_weight_sync | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: src/act_pingpong.sv
`timescale 1ns/10ps

module act_pingpong import conv_sync_pkg::*; (
	input  logic                   clk,
	input  logic                   wram_raddr_rst,
	input  sync_state_t            state,
	input  logic [ROW_AW-1:0]      img_h,
	input  logic                   rd_half,
	input  logic                   pass_start,
	input  logic                   act_valid,
	output logic                   act_ready,
	input  logic [ACT_WORD_W-1:0]  act_data,
	output logic                   fill_done,
	output logic                   drain_done,
	output logic                   act_out_fire,
	output logic                   m_act_valid,
	output logic [ACT_WORD_W-1:0]  m_act_data
);

	logic [ACT_WORD_W-1:0]  mem [2**(ROW_AW+1)];
	logic [ROW_AW-1:0]      wr_addr;
	logic [ROW_AW-1:0]      rd_addr;
	logic [ACT_WORD_W-1:0]  rd_q;
	logic                   wr_half;
	logic                   wr_fire;
	logic                   in_cal;
	logic                   in_job;
	logic                   rd_run;
	logic                   rd_en;
	logic                   rd_vld;     // rd_q holds a word
	logic                   rd_last;

	assign in_cal  = (state == ST_CAL_PING) || (state == ST_CAL_PONG);
	assign in_job  = in_cal || (state == ST_ACT_PRE);
	assign wr_half = (state == ST_CAL_PING);    // pre-fill and pong write half 0

	assign act_ready    = in_job && !fill_done;
	assign wr_fire      = act_valid && act_ready;
	assign rd_en        = rd_run && in_cal;
	assign act_out_fire = m_act_valid;

	//////////////////////////////////////////////////////////////////////
	// fill side
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wram_raddr_rst || !in_job || pass_start) begin
			wr_addr   <= '0;
			fill_done <= 1'b0;
		end else if (wr_fire) begin
			if (wr_addr == img_h - 1'b1) begin
				wr_addr   <= '0;
				fill_done <= 1'b1;    // half full so act_ready stays low
			end else begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// drain side with two cycles from read to output
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wram_raddr_rst || !in_cal) begin
			rd_run      <= 1'b0;
			rd_addr     <= '0;
			rd_vld      <= 1'b0;
			rd_last     <= 1'b0;
			drain_done  <= 1'b0;
			m_act_valid <= 1'b0;
		end else begin
			rd_vld      <= rd_en;
			rd_last     <= rd_en && (rd_addr == img_h - 1'b1);
			m_act_valid <= rd_vld;
			if (pass_start) begin
				rd_run  <= 1'b1;
				rd_addr <= '0;
			end else if (rd_en) begin
				if (rd_addr == img_h - 1'b1) begin
					rd_run  <= 1'b0;
					rd_addr <= '0;
				end else begin
					rd_addr <= rd_addr + 1'b1;
				end
			end
			// high together with the last output word
			if (pass_start) drain_done <= 1'b0;
			else if (rd_last) drain_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) mem[{wr_half, wr_addr}] <= act_data;
		if (rd_en) rd_q <= mem[{rd_half, rd_addr}];
		m_act_data <= rd_q;
	end

	a_no_write_into_read_half: assert property (@(posedge clk) disable iff (wram_raddr_rst)
		(wr_fire && in_cal) |-> wr_half != rd_half);

endmodule

// File: src/act_weight_sync.sv
`timescale 1ns/10ps

module act_weight_sync import conv_sync_pkg::*; (
	input  logic                                  clk,
	input  logic                                  wram_raddr_rst,
	input  logic                                  cfg_valid,
	output logic                                  cfg_ready,
	input  cfg_word_u                             cfg_data,
	input  logic [LANES-1:0]                      weight_valid,
	output logic [LANES-1:0]                      weight_ready,
	input  logic [LANES*WEIGHT_W-1:0]             weight_data,
	input  logic                                  act_valid,
	output logic                                  act_ready,
	input  logic [ACT_WORD_W-1:0]                 act_data,
	input  logic                                  ro_busy,
	output logic                                  m_act_valid,
	output logic [ACT_WORD_W-1:0]                 m_act_data,
	output logic [ROWS-1:0]                       m_weight_valid,
	output logic [LANES*KERNELS*WEIGHT_W-1:0]     m_weight_data
);

	sync_state_t         state;
	logic [ROW_AW-1:0]   img_h;
	logic [LEN_W-1:0]    weight_len;
	logic [LEN_W-1:0]    total_len;
	logic                cfg_done;
	logic                wram_waddr_clr;
	logic                pass_start;
	logic                rd_half;
	logic [LANES-1:0]    load_done;
	logic                fill_done;
	logic                drain_done;
	logic                act_out_fire;
	logic [WRAM_AW-1:0]  tap_addr;    // shared read address, all banks

	sync_config u_config (
		.clk, .wram_raddr_rst, .state,
		.cfg_valid, .cfg_ready, .cfg_data,
		.img_h, .weight_len, .total_len, .cfg_done
	);

	sync_ctrl u_ctrl (
		.clk, .wram_raddr_rst, .cfg_done, .load_done,
		.fill_done, .drain_done, .act_out_fire, .ro_busy, .total_len,
		.state, .wram_waddr_clr, .pass_start, .rd_half
	);

	act_pingpong u_act (
		.clk, .wram_raddr_rst, .state, .img_h, .rd_half, .pass_start,
		.act_valid, .act_ready, .act_data,
		.fill_done, .drain_done, .act_out_fire, .m_act_valid, .m_act_data
	);

	weight_tap_seq u_taps (
		.clk, .wram_raddr_rst, .pass_start,
		.rd_addr(tap_addr), .m_weight_valid
	);

	// lane-major, bank-minor on the weight output
	for (genvar l = 0; l < LANES; l++) begin : g_lane
		weight_bank u_bank (
			.clk, .state, .wram_waddr_clr, .weight_len,
			.weight_valid (weight_valid[l]),
			.weight_ready (weight_ready[l]),
			.weight_data  (weight_data[l*WEIGHT_W +: WEIGHT_W]),
			.rd_addr      (tap_addr),
			.bank_dout    (m_weight_data[l*KERNELS*WEIGHT_W +: KERNELS*WEIGHT_W]),
			.load_done    (load_done[l])
		);
	end

endmodule

// File: src/conv_sync_pkg.sv
package conv_sync_pkg;

	localparam int ACT_W      = 12;
	localparam int ACT_WORD_W = 4 * ACT_W;    // four values per word
	localparam int WEIGHT_W   = 4;
	localparam int LANES      = 4;
	localparam int KERNELS    = 4;            // banks per lane
	localparam int TAPS       = 9;
	localparam int ROWS       = 3;
	localparam int WRAM_AW    = 6;
	localparam int ROW_AW     = 9;            // one activation half
	localparam int CFG_W      = 32;
	localparam int LEN_W      = 24;
	localparam int CFG_WORDS  = 3;

	typedef enum logic [2:0] {
		ST_CONFIG,
		ST_GET_WEIGHT,
		ST_ACT_PRE,
		ST_CAL_PING,
		ST_CAL_PONG
	} sync_state_t;

	// word 0 is read as a shape, words 1 and 2 as lengths
	typedef union packed {
		struct packed {
			logic [CFG_W-ROW_AW-1:0] rsvd;
			logic [ROW_AW-1:0]       img_h;
		} shape;
		struct packed {
			logic [CFG_W-LEN_W-1:0]  rsvd;
			logic [LEN_W-1:0]        length;
		} len;
	} cfg_word_u;

endpackage

// File: src/sync_config.sv
`timescale 1ns/10ps

module sync_config import conv_sync_pkg::*; (
	input  logic               clk,
	input  logic               wram_raddr_rst,
	input  sync_state_t        state,
	input  logic               cfg_valid,
	output logic               cfg_ready,
	input  cfg_word_u          cfg_data,
	output logic [ROW_AW-1:0]  img_h,
	output logic [LEN_W-1:0]   weight_len,
	output logic [LEN_W-1:0]   total_len,
	output logic               cfg_done
);

	logic [$clog2(CFG_WORDS)-1:0] cfg_cnt;
	logic                         cfg_taken;    // all words in until the state moves on
	logic                         cfg_fire;

	assign cfg_ready = (state == ST_CONFIG) && !cfg_taken;
	assign cfg_fire  = cfg_valid && cfg_ready;

	always_ff @(posedge clk) begin
		if (wram_raddr_rst) begin
			cfg_cnt   <= '0;
			cfg_taken <= 1'b0;
			cfg_done  <= 1'b0;
		end else begin
			cfg_done <= cfg_fire && (cfg_cnt == CFG_WORDS - 1);
			if (state != ST_CONFIG) cfg_taken <= 1'b0;
			if (cfg_fire) begin
				if (cfg_cnt == CFG_WORDS - 1) begin
					cfg_cnt   <= '0;
					cfg_taken <= 1'b1;
				end else begin
					cfg_cnt <= cfg_cnt + 1'b1;
				end
			end
		end
	end

	// words arrive as shape, weight length, total length
	always_ff @(posedge clk) begin
		if (cfg_fire) begin
			case (cfg_cnt)
				2'd0:    img_h      <= cfg_data.shape.img_h;
				2'd1:    weight_len <= cfg_data.len.length;
				default: total_len  <= cfg_data.len.length;
			endcase
		end
	end

	a_cfg_only_in_config: assert property (@(posedge clk) disable iff (wram_raddr_rst)
		state != ST_CONFIG |=> $stable(img_h) && $stable(weight_len) && $stable(total_len));

	a_cfg_done_starts_load: assert property (@(posedge clk) disable iff (wram_raddr_rst)
		cfg_done |=> state == ST_GET_WEIGHT);

endmodule

// File: src/sync_ctrl.sv
`timescale 1ns/10ps

module sync_ctrl import conv_sync_pkg::*; (
	input  logic              clk,
	input  logic              wram_raddr_rst,
	input  logic              cfg_done,
	input  logic [LANES-1:0]  load_done,
	input  logic              fill_done,
	input  logic              drain_done,
	input  logic              act_out_fire,
	input  logic              ro_busy,
	input  logic [LEN_W-1:0]  total_len,
	output sync_state_t       state,
	output logic              wram_waddr_clr,
	output logic              pass_start,
	output logic              rd_half
);

	sync_state_t       nxt;
	logic [LEN_W-1:0]  out_cnt;
	logic              job_end;
	logic              swap;

	assign job_end = act_out_fire && (out_cnt == total_len - 1'b1);
	// pass_start cycle still shows the flags of the previous pass
	assign swap    = drain_done && fill_done && !ro_busy && !pass_start;

	assign wram_waddr_clr = (state == ST_CONFIG);
	assign rd_half        = (state == ST_CAL_PONG);    // ping reads half 0

	//////////////////////////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		nxt = state;
		unique case (state)
			ST_CONFIG:     if (cfg_done) nxt = ST_GET_WEIGHT;
			ST_GET_WEIGHT: if (&load_done) nxt = ST_ACT_PRE;
			ST_ACT_PRE:    if (fill_done) nxt = ST_CAL_PING;
			ST_CAL_PING: begin
				if (job_end) nxt = ST_CONFIG;
				else if (swap) nxt = ST_CAL_PONG;
			end
			ST_CAL_PONG: begin
				if (job_end) nxt = ST_CONFIG;
				else if (swap) nxt = ST_CAL_PING;
			end
			default:       nxt = ST_CONFIG;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wram_raddr_rst) begin
			state      <= ST_CONFIG;
			pass_start <= 1'b0;
		end else begin
			state      <= nxt;
			pass_start <= (nxt == ST_CAL_PING || nxt == ST_CAL_PONG) && (nxt != state);
		end
	end

	// emitted words of the current job
	always_ff @(posedge clk) begin
		if (wram_raddr_rst || state == ST_CONFIG) out_cnt <= '0;
		else if (act_out_fire) out_cnt <= out_cnt + 1'b1;
	end

	a_state_legal: assert property (@(posedge clk) disable iff (wram_raddr_rst)
		state inside {ST_CONFIG, ST_GET_WEIGHT, ST_ACT_PRE, ST_CAL_PING, ST_CAL_PONG});

endmodule

// File: src/weight_bank.sv
`timescale 1ns/10ps

module weight_bank import conv_sync_pkg::*; (
	input  logic                          clk,
	input  sync_state_t                   state,
	input  logic                          wram_waddr_clr,
	input  logic [LEN_W-1:0]              weight_len,
	input  logic                          weight_valid,
	output logic                          weight_ready,
	input  logic [WEIGHT_W-1:0]           weight_data,
	input  logic [WRAM_AW-1:0]            rd_addr,
	output logic [KERNELS*WEIGHT_W-1:0]   bank_dout,
	output logic                          load_done
);

	logic [WEIGHT_W-1:0]         mem [KERNELS][2**WRAM_AW];
	logic [WRAM_AW-1:0]          waddr [KERNELS];
	logic [KERNELS-1:0]          sel;        // one-hot write bank
	logic [$clog2(TAPS)-1:0]     tap_cnt;
	logic [LEN_W-1:0]            wcnt;
	logic                        we;

	assign weight_ready = (state == ST_GET_WEIGHT) && !load_done;
	assign we           = weight_valid && weight_ready;

	always_ff @(posedge clk) begin
		if (wram_waddr_clr) begin
			sel       <= KERNELS'(1);
			tap_cnt   <= '0;
			wcnt      <= '0;
			load_done <= 1'b0;
			for (int k = 0; k < KERNELS; k++) waddr[k] <= '0;
		end else if (we) begin
			wcnt <= wcnt + 1'b1;
			if (wcnt == weight_len - 1'b1) load_done <= 1'b1;
			for (int k = 0; k < KERNELS; k++) begin
				if (sel[k]) waddr[k] <= waddr[k] + 1'b1;
			end
			// nine words per kernel, then next bank
			if (tap_cnt == TAPS - 1) begin
				tap_cnt <= '0;
				sel     <= {sel[KERNELS-2:0], sel[KERNELS-1]};
			end else begin
				tap_cnt <= tap_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < KERNELS; k++) begin
			if (we && sel[k]) mem[k][waddr[k]] <= weight_data;
			bank_dout[k*WEIGHT_W +: WEIGHT_W] <= mem[k][rd_addr];    // one cycle read
		end
	end

endmodule

// File: src/weight_tap_seq.sv
`timescale 1ns/10ps

module weight_tap_seq import conv_sync_pkg::*; (
	input  logic                clk,
	input  logic                wram_raddr_rst,
	input  logic                pass_start,
	output logic [WRAM_AW-1:0]  rd_addr,
	output logic [ROWS-1:0]     m_weight_valid
);

	logic             run;
	logic [ROWS-1:0]  row_pre;

	// taps 0-2 row 0, 3-5 row 1, 6-8 row 2
	assign row_pre = run ? (ROWS'(1) << (rd_addr / (TAPS / ROWS))) : '0;

	always_ff @(posedge clk) begin
		if (wram_raddr_rst) begin
			run            <= 1'b0;
			rd_addr        <= '0;
			m_weight_valid <= '0;
		end else begin
			m_weight_valid <= row_pre;    // lines up with registered bank data
			if (pass_start) begin
				run     <= 1'b1;
				rd_addr <= '0;
			end else if (run) begin
				if (rd_addr == TAPS - 1) begin
					run     <= 1'b0;
					rd_addr <= '0;
				end else begin
					rd_addr <= rd_addr + 1'b1;
				end
			end
		end
	end

	a_marker_onehot: assert property (@(posedge clk) disable iff (wram_raddr_rst)
		$onehot0(m_weight_valid));

	a_marker_nine: assert property (@(posedge clk) disable iff (wram_raddr_rst)
		$rose(|m_weight_valid) |-> (|m_weight_valid) [*TAPS] ##1 !(|m_weight_valid));

endmodule

// File: tb.f
src/conv_sync_pkg.sv
src/sync_config.sv
src/sync_ctrl.sv
src/weight_bank.sv
src/weight_tap_seq.sv
src/act_pingpong.sv
src/act_weight_sync.sv
test/tb_clk_gen.sv
test/tb_act_weight_sync.sv

// File: test/tb_act_weight_sync.sv
`timescale 1ns/10ps

module tb_act_weight_sync import conv_sync_pkg::*; ();

	localparam int CLK_PERIOD  = 100;
	localparam int IMG_H       = 8;
	localparam int WEIGHT_LEN  = 36;
	localparam int TOTAL_LEN   = 32;
	localparam int JOBS        = 2;
	localparam int WDOG_CYCLES = JOBS * (10 * WEIGHT_LEN + 10 * TOTAL_LEN + 100);

	logic                               clk;
	logic                               wram_raddr_rst;
	logic                               cfg_valid;
	logic                               cfg_ready;
	logic [CFG_W-1:0]                   cfg_data;
	logic [LANES-1:0]                   weight_valid;
	logic [LANES-1:0]                   weight_ready;
	logic [LANES*WEIGHT_W-1:0]          weight_data;
	logic                               act_valid;
	logic                               act_ready;
	logic [ACT_WORD_W-1:0]              act_data;
	logic                               ro_busy;
	logic                               m_act_valid;
	logic [ACT_WORD_W-1:0]              m_act_data;
	logic [ROWS-1:0]                    m_weight_valid;
	logic [LANES*KERNELS*WEIGHT_W-1:0]  m_weight_data;

	integer                 seed;
	int                     errors;
	int                     checks;
	logic [WEIGHT_W-1:0]    wsent [LANES][WEIGHT_LEN];    // weights sent this job
	logic [ACT_WORD_W-1:0]  act_src [TOTAL_LEN];
	logic [ACT_WORD_W-1:0]  exp_q [$];                    // accepted, not yet emitted
	int                     out_cnt;
	int                     pass_cnt;
	int                     tap_idx;
	logic                   last_seen;
	logic                   job_done;

	tb_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk);

	act_weight_sync u_dut (
		.clk, .wram_raddr_rst,
		.cfg_valid, .cfg_ready, .cfg_data,
		.weight_valid, .weight_ready, .weight_data,
		.act_valid, .act_ready, .act_data, .ro_busy,
		.m_act_valid, .m_act_data, .m_weight_valid, .m_weight_data
	);

	// weight k*9+t of a lane lands at address t of bank k
	function automatic logic [WEIGHT_W-1:0] exp_weight(input int lane, input int kernel,
			input int tap);
		return wsent[lane][kernel * TAPS + tap];
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic make_job_data();
		for (int l = 0; l < LANES; l++) begin
			for (int i = 0; i < WEIGHT_LEN; i++) wsent[l][i] = WEIGHT_W'($random(seed));
		end
		for (int i = 0; i < TOTAL_LEN; i++) begin
			act_src[i] = ACT_WORD_W'({$random(seed), $random(seed)});
		end
	endtask

	// called and returns just after a rising edge
	task automatic send_cfg(input logic [CFG_W-1:0] word);
		logic taken;
		taken     = 1'b0;
		cfg_valid = 1'b1;
		cfg_data  = word;
		while (!taken) begin
			@(negedge clk);
			taken = cfg_ready;
			@(posedge clk);
			#1;
		end
		cfg_valid = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// weight load with random gaps per lane
	//////////////////////////////////////////////////////////////////////
	task automatic load_weights();
		int   idx [LANES];
		logic fire [LANES];
		logic seen [LANES];
		logic busy;
		for (int l = 0; l < LANES; l++) begin
			idx[l]  = 0;
			seen[l] = 1'b0;
		end
		busy = 1'b1;
		while (busy) begin
			for (int l = 0; l < LANES; l++) begin
				weight_valid[l] = (idx[l] < WEIGHT_LEN) && (($random(seed) & 3) != 0);
				weight_data[l*WEIGHT_W +: WEIGHT_W] =
					(idx[l] < WEIGHT_LEN) ? wsent[l][idx[l]] : '0;
			end
			@(negedge clk);
			for (int l = 0; l < LANES; l++) begin
				fire[l] = weight_valid[l] && weight_ready[l];
				if (idx[l] == WEIGHT_LEN) begin
					check_value($sformatf("weight_ready[%0d]", l), weight_ready[l], 0);
				end else if (weight_ready[l]) begin
					seen[l] = 1'b1;
				end else if (seen[l]) begin
					errors++;
					seen[l] = 1'b0;
					$display("lane %0d dropped weight_ready after only %0d words", l, idx[l]);
				end
			end
			@(posedge clk);
			#1;
			busy = 1'b0;
			for (int l = 0; l < LANES; l++) begin
				if (fire[l]) idx[l]++;
				if (idx[l] < WEIGHT_LEN) busy = 1'b1;
			end
		end
		weight_valid = '0;
		@(negedge clk);
		for (int l = 0; l < LANES; l++) begin
			check_value($sformatf("weight_ready[%0d]", l), weight_ready[l], 0);
		end
		@(posedge clk);
		#1;
	endtask

	// feeds exactly TOTAL_LEN words, ends once cfg_ready is back
	task automatic run_activations();
		int   sent;
		logic fire;
		sent = 0;
		while (!job_done) begin
			act_valid = (sent < TOTAL_LEN) && (($random(seed) & 3) != 0);
			act_data  = (sent < TOTAL_LEN) ? act_src[sent] : '0;
			ro_busy   = ($random(seed) & 3) == 0;
			@(negedge clk);
			fire = act_valid && act_ready;
			@(posedge clk);
			#1;
			if (fire) begin
				exp_q.push_back(act_data);
				sent++;
			end
		end
		act_valid = 1'b0;
		ro_busy   = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare outputs on the falling edge
	//////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin : compare
		logic [ACT_WORD_W-1:0] exp_word;
		logic [ROWS-1:0]       exp_row;
		if (!wram_raddr_rst) begin
			if (last_seen) begin
				check_value("cfg_ready", cfg_ready, 1);
				last_seen = 1'b0;
				job_done  = 1'b1;
			end
			if (m_act_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("output word %0h at %0t ns has no input word to match",
						m_act_data, $time);
				end else begin
					exp_word = exp_q.pop_front();
					check_value("m_act_data", m_act_data, exp_word);
				end
				out_cnt++;
				if (out_cnt == TOTAL_LEN) last_seen = 1'b1;
			end
			if (m_weight_valid != '0) begin
				if (tap_idx >= TAPS) begin
					errors++;
					$display("row marker still set at %0t ns after nine taps", $time);
				end else begin
					exp_row = '0;
					exp_row[tap_idx / 3] = 1'b1;    // three taps per row
					check_value("m_weight_valid", m_weight_valid, exp_row);
					for (int l = 0; l < LANES; l++) begin
						for (int k = 0; k < KERNELS; k++) begin
							check_value($sformatf("m_weight_data lane %0d bank %0d", l, k),
								m_weight_data[(l*KERNELS+k)*WEIGHT_W +: WEIGHT_W],
								exp_weight(l, k, tap_idx));
						end
					end
				end
				tap_idx++;
			end else if (tap_idx != 0) begin
				if (tap_idx != TAPS) begin
					errors++;
					$display("row marker lasted %0d cycles, not nine", tap_idx);
				end
				pass_cnt++;
				tap_idx = 0;
			end
		end
	end

	initial begin
		#(WDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", WDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		seed           = 32'h2d30;
		errors         = 0;
		checks         = 0;
		tap_idx        = 0;
		out_cnt        = 0;
		pass_cnt       = 0;
		last_seen      = 1'b0;
		job_done       = 1'b0;
		wram_raddr_rst = 1'b1;
		cfg_valid      = 1'b0;
		cfg_data       = '0;
		weight_valid   = '0;
		weight_data    = '0;
		act_valid      = 1'b0;
		act_data       = '0;
		ro_busy        = 1'b0;
		repeat (3) @(posedge clk);
		#1 wram_raddr_rst = 1'b0;

		@(negedge clk);
		check_value("cfg_ready", cfg_ready, 1);
		check_value("act_ready", act_ready, 0);
		check_value("weight_ready", weight_ready, 0);
		check_value("m_act_valid", m_act_valid, 0);
		check_value("m_weight_valid", m_weight_valid, 0);
		@(posedge clk);
		#1;

		for (int job = 0; job < JOBS; job++) begin
			make_job_data();
			out_cnt  = 0;
			pass_cnt = 0;
			job_done = 1'b0;
			send_cfg(CFG_W'(IMG_H));       // shape
			send_cfg(CFG_W'(WEIGHT_LEN));
			send_cfg(CFG_W'(TOTAL_LEN));
			@(negedge clk);
			check_value("cfg_ready", cfg_ready, 0);
			@(posedge clk);
			#1;
			load_weights();
			run_activations();
			check_value("tap passes", pass_cnt, TOTAL_LEN / IMG_H);
			check_value("words left over", exp_q.size(), 0);
		end

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

endmodule
